// ==== src/sm_iface_pkg.sv ====
`default_nettype none

package sm_iface_pkg;

    // processor word for addresses, register values and module ids
    typedef logic [15:0] word_t;

    // requests to the protection logic, answered on sm_data in the same cycle
    typedef enum logic [2:0] {
        req_none      = 3'd0,
        req_pub_start = 3'd1,
        req_pub_end   = 3'd2,
        req_sec_start = 3'd3,
        req_sec_end   = 3'd4,
        req_id        = 3'd5
    } sm_req_t;

endpackage

`default_nettype wire

// ==== src/crypto_ctrl_pkg.sv ====
`default_nettype none

package crypto_ctrl_pkg;

    // byte distance between consecutive words
    localparam sm_iface_pkg::word_t addr_step = 16'd2;

    // one-hot register file masks
    localparam sm_iface_pkg::word_t dest_r15 = 16'h8000;
    localparam sm_iface_pkg::word_t dest_pc  = 16'h0001;

    // byte enables for a full word write
    localparam logic [1:0] mb_wr_word = 2'b11;

    typedef enum logic [1:0] {
        res_fail     = 2'd0,
        res_id       = 2'd1,
        res_prev_id  = 2'd2,
        res_disabled = 2'd3
    } result_t;

    typedef enum logic [3:0] {
        st_idle       = 4'd0,
        st_check      = 4'd1,
        st_code_init1 = 4'd2,
        st_code_init2 = 4'd3,
        st_code_wipe  = 4'd4,
        st_data_init1 = 4'd5,
        st_data_init2 = 4'd6,
        st_data_wipe  = 4'd7,
        st_fail       = 4'd8,
        st_success    = 4'd9,
        st_wait       = 4'd10
    } state_t;

endpackage

`default_nettype wire

// ==== src/sm_command_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_command_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    cmd_disable,
    input  logic                    cmd_id,
    input  logic                    cmd_id_prev,
    input  sm_iface_pkg::word_t     pc,
    input  sm_iface_pkg::word_t     r15,
    input  sm_iface_pkg::word_t     sm_prev_id,
    input  logic                    sm_data_select_valid,
    input  logic                    sm_key_select_valid,
    input  logic                    range_done,
    output logic                    busy,
    output sm_iface_pkg::sm_req_t   sm_request,
    output sm_iface_pkg::word_t     sm_data_select,
    output logic                    range_base_load,
    output logic                    range_limit_load,
    output logic                    wipe,
    output logic                    result_strobe,
    output crypto_ctrl_pkg::result_t result_kind
);

    crypto_ctrl_pkg::state_t state;
    crypto_ctrl_pkg::state_t next_state;
    logic                    sel_valid;

    always_comb
    begin
        case (state)
            crypto_ctrl_pkg::st_idle:
                next_state = start ? crypto_ctrl_pkg::st_check : crypto_ctrl_pkg::st_idle;
            crypto_ctrl_pkg::st_check:
            begin
                if (!sel_valid)
                    next_state = crypto_ctrl_pkg::st_fail;
                else if (cmd_disable)
                    next_state = crypto_ctrl_pkg::st_code_init1;
                else if (cmd_id | cmd_id_prev)
                    next_state = crypto_ctrl_pkg::st_success;
                else
                    next_state = crypto_ctrl_pkg::st_fail;
            end
            crypto_ctrl_pkg::st_code_init1:
                next_state = crypto_ctrl_pkg::st_code_init2;
            crypto_ctrl_pkg::st_code_init2:
                next_state = crypto_ctrl_pkg::st_code_wipe;
            crypto_ctrl_pkg::st_code_wipe:
                next_state = range_done ? crypto_ctrl_pkg::st_data_init1
                                        : crypto_ctrl_pkg::st_code_wipe;
            crypto_ctrl_pkg::st_data_init1:
                next_state = crypto_ctrl_pkg::st_data_init2;
            crypto_ctrl_pkg::st_data_init2:
                next_state = crypto_ctrl_pkg::st_data_wipe;
            crypto_ctrl_pkg::st_data_wipe:
                next_state = range_done ? crypto_ctrl_pkg::st_success
                                        : crypto_ctrl_pkg::st_data_wipe;
            crypto_ctrl_pkg::st_success:
                next_state = cmd_disable ? crypto_ctrl_pkg::st_wait : crypto_ctrl_pkg::st_idle;
            default:
                next_state = crypto_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= crypto_ctrl_pkg::st_idle;
        else
            state <= next_state;
    end

    // validity is sampled on the edge that enters check
    always_ff @(posedge clk)
    begin
        if (reset)
            sel_valid <= 1'b0;
        else if (next_state == crypto_ctrl_pkg::st_check)
            sel_valid <= (!cmd_id | sm_data_select_valid) &
                         (!cmd_disable | sm_key_select_valid);
    end

    // outputs follow the state being entered
    always_comb
    begin
        busy             = 1'b1;
        sm_request       = sm_iface_pkg::req_none;
        range_base_load  = 1'b0;
        range_limit_load = 1'b0;
        wipe             = 1'b0;
        result_strobe    = 1'b0;
        result_kind      = crypto_ctrl_pkg::res_fail;

        case (next_state)
            crypto_ctrl_pkg::st_idle:
                busy = 1'b0;
            crypto_ctrl_pkg::st_code_init1:
            begin
                sm_request      = sm_iface_pkg::req_pub_start;
                range_base_load = 1'b1;
            end
            crypto_ctrl_pkg::st_code_init2:
            begin
                sm_request       = sm_iface_pkg::req_pub_end;
                range_limit_load = 1'b1;
            end
            crypto_ctrl_pkg::st_data_init1:
            begin
                sm_request      = sm_iface_pkg::req_sec_start;
                range_base_load = 1'b1;
            end
            crypto_ctrl_pkg::st_data_init2:
            begin
                sm_request       = sm_iface_pkg::req_sec_end;
                range_limit_load = 1'b1;
            end
            crypto_ctrl_pkg::st_code_wipe,
            crypto_ctrl_pkg::st_data_wipe:
                wipe = 1'b1;
            crypto_ctrl_pkg::st_fail:
                result_strobe = 1'b1;
            crypto_ctrl_pkg::st_success:
            begin
                // id answer is taken by the writeback in this cycle
                sm_request    = sm_iface_pkg::req_id;
                result_strobe = 1'b1;
                if (cmd_disable)
                    result_kind = crypto_ctrl_pkg::res_disabled;
                else if (cmd_id_prev)
                    result_kind = crypto_ctrl_pkg::res_prev_id;
                else
                    result_kind = crypto_ctrl_pkg::res_id;
            end
            default:
            begin
            end
        endcase
    end

    always_comb
    begin
        if (cmd_disable)
            sm_data_select = pc;
        else if (cmd_id)
            sm_data_select = r15;
        else if (cmd_id_prev)
            sm_data_select = sm_prev_id;
        else
            sm_data_select = '0;
    end

    a_idle_no_request: assert property (@(posedge clk) disable iff (reset)
        !busy |-> sm_request == sm_iface_pkg::req_none);

    a_cmd_onehot: assert property (@(posedge clk) disable iff (reset)
        start |-> $onehot({cmd_disable, cmd_id, cmd_id_prev}));

endmodule

`default_nettype wire

// ==== src/address_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module address_walker (
    input  logic                clk,
    input  logic                reset,
    input  logic                range_base_load,
    input  logic                range_limit_load,
    input  logic                wipe,
    input  sm_iface_pkg::word_t sm_data,
    output logic                range_done,
    output sm_iface_pkg::word_t mab,
    output logic                mb_en,
    output logic [1:0]          mb_wr
);

    sm_iface_pkg::word_t addr_ctr;
    sm_iface_pkg::word_t addr_limit;

    always_ff @(posedge clk)
    begin
        if (reset)
            addr_ctr <= '0;
        else if (range_base_load)
            addr_ctr <= sm_data;
        else if (wipe)
            addr_ctr <= addr_ctr + crypto_ctrl_pkg::addr_step;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            addr_limit <= '0;
        else if (range_limit_load)
            addr_limit <= sm_data;
    end

    // range end is exclusive
    assign range_done = addr_ctr >= addr_limit;

    // zero word writes, data side is fixed at zero
    assign mab   = addr_ctr;
    assign mb_en = wipe;
    assign mb_wr = wipe ? crypto_ctrl_pkg::mb_wr_word : 2'b00;

    a_wr_needs_en: assert property (@(posedge clk) disable iff (reset)
        (mb_wr != 2'b00) |-> mb_en);

endmodule

`default_nettype wire

// ==== src/result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     result_strobe,
    input  crypto_ctrl_pkg::result_t result_kind,
    input  sm_iface_pkg::word_t      r15,
    input  sm_iface_pkg::word_t      sm_data,
    input  sm_iface_pkg::word_t      sm_prev_id,
    output logic                     stat_wr,
    output logic                     reg_write,
    output sm_iface_pkg::word_t      dest_reg,
    output sm_iface_pkg::word_t      reg_data_out
);

    sm_iface_pkg::word_t dest_val;
    sm_iface_pkg::word_t data_val;

    always_comb
    begin
        case (result_kind)
            crypto_ctrl_pkg::res_id:
            begin
                dest_val = crypto_ctrl_pkg::dest_r15;
                data_val = sm_data;
            end
            crypto_ctrl_pkg::res_prev_id:
            begin
                dest_val = crypto_ctrl_pkg::dest_r15;
                data_val = sm_prev_id;
            end
            // return address goes back to pc
            crypto_ctrl_pkg::res_disabled:
            begin
                dest_val = crypto_ctrl_pkg::dest_pc;
                data_val = r15;
            end
            default:
            begin
                dest_val = crypto_ctrl_pkg::dest_r15;
                data_val = '0;
            end
        endcase
    end

    // one cycle register file write
    always_ff @(posedge clk)
    begin
        if (reset | !result_strobe)
        begin
            reg_write    <= 1'b0;
            dest_reg     <= '0;
            reg_data_out <= '0;
        end
        else
        begin
            reg_write    <= 1'b1;
            dest_reg     <= dest_val;
            reg_data_out <= data_val;
        end
    end

    assign stat_wr = result_strobe;

    a_dest_onehot: assert property (@(posedge clk) disable iff (reset)
        reg_write |-> $onehot(dest_reg));

endmodule

`default_nettype wire

// ==== src/crypto_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module crypto_control (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  cmd_disable,
    input  logic                  cmd_id,
    input  logic                  cmd_id_prev,
    input  sm_iface_pkg::word_t   pc,
    input  sm_iface_pkg::word_t   r15,
    input  sm_iface_pkg::word_t   sm_data,
    input  sm_iface_pkg::word_t   sm_prev_id,
    input  logic                  sm_data_select_valid,
    input  logic                  sm_key_select_valid,
    output logic                  busy,
    output sm_iface_pkg::sm_req_t sm_request,
    output sm_iface_pkg::word_t   sm_data_select,
    output logic                  mb_en,
    output logic [1:0]            mb_wr,
    output sm_iface_pkg::word_t   mab,
    output logic                  reg_write,
    output sm_iface_pkg::word_t   dest_reg,
    output sm_iface_pkg::word_t   reg_data_out,
    output logic                  stat_wr
);

    logic                     range_base_load;
    logic                     range_limit_load;
    logic                     wipe;
    logic                     range_done;
    logic                     result_strobe;
    crypto_ctrl_pkg::result_t result_kind;

    sm_command_sequencer u_seq (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .cmd_disable          (cmd_disable),
        .cmd_id               (cmd_id),
        .cmd_id_prev          (cmd_id_prev),
        .pc                   (pc),
        .r15                  (r15),
        .sm_prev_id           (sm_prev_id),
        .sm_data_select_valid (sm_data_select_valid),
        .sm_key_select_valid  (sm_key_select_valid),
        .range_done           (range_done),
        .busy                 (busy),
        .sm_request           (sm_request),
        .sm_data_select       (sm_data_select),
        .range_base_load      (range_base_load),
        .range_limit_load     (range_limit_load),
        .wipe                 (wipe),
        .result_strobe        (result_strobe),
        .result_kind          (result_kind)
    );

    address_walker u_walker (
        .clk              (clk),
        .reset            (reset),
        .range_base_load  (range_base_load),
        .range_limit_load (range_limit_load),
        .wipe             (wipe),
        .sm_data          (sm_data),
        .range_done       (range_done),
        .mab              (mab),
        .mb_en            (mb_en),
        .mb_wr            (mb_wr)
    );

    result_writeback u_wb (
        .clk           (clk),
        .reset         (reset),
        .result_strobe (result_strobe),
        .result_kind   (result_kind),
        .r15           (r15),
        .sm_data       (sm_data),
        .sm_prev_id    (sm_prev_id),
        .stat_wr       (stat_wr),
        .reg_write     (reg_write),
        .dest_reg      (dest_reg),
        .reg_data_out  (reg_data_out)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_crypto_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_crypto_control;

    localparam int max_wait = 200;

    logic                  clk;
    logic                  reset;
    logic                  start;
    logic                  cmd_disable;
    logic                  cmd_id;
    logic                  cmd_id_prev;
    sm_iface_pkg::word_t   pc;
    sm_iface_pkg::word_t   r15;
    sm_iface_pkg::word_t   sm_data;
    sm_iface_pkg::word_t   sm_prev_id;
    logic                  sm_data_select_valid;
    logic                  sm_key_select_valid;
    logic                  busy;
    sm_iface_pkg::sm_req_t sm_request;
    sm_iface_pkg::word_t   sm_data_select;
    logic                  mb_en;
    logic [1:0]            mb_wr;
    sm_iface_pkg::word_t   mab;
    logic                  reg_write;
    sm_iface_pkg::word_t   dest_reg;
    sm_iface_pkg::word_t   reg_data_out;
    logic                  stat_wr;

    // protection logic model contents
    sm_iface_pkg::word_t pub_start;
    sm_iface_pkg::word_t pub_end;
    sm_iface_pkg::word_t sec_start;
    sm_iface_pkg::word_t sec_end;
    sm_iface_pkg::word_t module_id;

    sm_iface_pkg::word_t writes[$];
    sm_iface_pkg::word_t expected[$];

    int checks;
    int errors;
    int seed;

    // what the last command returned
    logic                found;
    int                  write_edge;
    logic                stat_before;
    logic                busy_at_write;
    sm_iface_pkg::word_t got_dest;
    sm_iface_pkg::word_t got_data;

    crypto_control dut0 (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .cmd_disable          (cmd_disable),
        .cmd_id               (cmd_id),
        .cmd_id_prev          (cmd_id_prev),
        .pc                   (pc),
        .r15                  (r15),
        .sm_data              (sm_data),
        .sm_prev_id           (sm_prev_id),
        .sm_data_select_valid (sm_data_select_valid),
        .sm_key_select_valid  (sm_key_select_valid),
        .busy                 (busy),
        .sm_request           (sm_request),
        .sm_data_select       (sm_data_select),
        .mb_en                (mb_en),
        .mb_wr                (mb_wr),
        .mab                  (mab),
        .reg_write            (reg_write),
        .dest_reg             (dest_reg),
        .reg_data_out         (reg_data_out),
        .stat_wr              (stat_wr)
    );

    always #20 clk = ~clk;

    // protection logic answers in the same cycle
    always_comb
    begin
        case (sm_request)
            sm_iface_pkg::req_pub_start: sm_data = pub_start;
            sm_iface_pkg::req_pub_end:   sm_data = pub_end;
            sm_iface_pkg::req_sec_start: sm_data = sec_start;
            sm_iface_pkg::req_sec_end:   sm_data = sec_end;
            sm_iface_pkg::req_id:        sm_data = module_id;
            default:                     sm_data = '0;
        endcase
    end

    task automatic expect_word(input string name, input sm_iface_pkg::word_t got,
                               input sm_iface_pkg::word_t exp);
    begin
        checks++;
        assert (got === exp) else
        begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    end
    endtask

    task automatic expect_true(input logic cond, input string what);
    begin
        checks++;
        assert (cond === 1'b1) else
        begin
            errors++;
            $display("%s", what);
        end
    end
    endtask

    // memory side, mid cycle
    always @(negedge clk)
    begin
        if (!reset && mb_en)
        begin
            writes.push_back(mab);
            expect_word("mb_wr", {14'd0, mb_wr}, {14'd0, crypto_ctrl_pkg::mb_wr_word});
        end
    end

    task automatic run_command(input logic dis, input logic id, input logic prev,
                               input logic dsv, input logic ksv);
        int   n;
        logic last_stat;
    begin
        writes.delete();
        found = 1'b0;
        last_stat = 1'b0;
        busy_at_write = 1'b0;
        got_dest = '0;
        got_data = '0;
        @(negedge clk);
        cmd_disable = dis;
        cmd_id = id;
        cmd_id_prev = prev;
        sm_data_select_valid = dsv;
        sm_key_select_valid = ksv;
        start = 1'b1;
        write_edge = 0;
        while (!found && write_edge < max_wait)
        begin
            @(negedge clk);
            write_edge++;
            if (write_edge == 1)
                expect_word("sm_data_select", sm_data_select,
                            dis ? pc : (id ? r15 : sm_prev_id));
            if (reg_write)
            begin
                found = 1'b1;
                got_dest = dest_reg;
                got_data = reg_data_out;
                busy_at_write = busy;
            end
            else
                last_stat = stat_wr;
            start = 1'b0;
        end
        expect_true(found, "timeout while waiting for reg_write");
        stat_before = last_stat;
        if (found)
        begin
            @(negedge clk);
            expect_word("reg_write", {15'd0, reg_write}, 16'd0);
        end
        n = 0;
        while (busy && n < max_wait)
        begin
            @(negedge clk);
            n++;
        end
        expect_true(!busy, "timeout while waiting for busy to fall");
        cmd_disable = 1'b0;
        cmd_id = 1'b0;
        cmd_id_prev = 1'b0;
        sm_data_select_valid = 1'b0;
        sm_key_select_valid = 1'b0;
    end
    endtask

    // start word is always written, end is exclusive
    task automatic add_range(input sm_iface_pkg::word_t s, input sm_iface_pkg::word_t e);
        sm_iface_pkg::word_t a;
    begin
        a = s;
        expected.push_back(a);
        a = a + crypto_ctrl_pkg::addr_step;
        while (a < e)
        begin
            expected.push_back(a);
            a = a + crypto_ctrl_pkg::addr_step;
        end
    end
    endtask

    task automatic compare_writes();
        int i;
    begin
        expect_word("write count", 16'(writes.size()), 16'(expected.size()));
        for (i = 0; i < writes.size() && i < expected.size(); i++)
            expect_word("mab", writes[i], expected[i]);
    end
    endtask

    task automatic check_after_reset();
    begin
        @(negedge clk);
        expect_word("busy", {15'd0, busy}, 16'd0);
        expect_word("mb_en", {15'd0, mb_en}, 16'd0);
        expect_word("reg_write", {15'd0, reg_write}, 16'd0);
        expect_word("stat_wr", {15'd0, stat_wr}, 16'd0);
        expect_word("sm_request", {13'd0, sm_request}, {13'd0, sm_iface_pkg::req_none});
    end
    endtask

    task automatic identify_valid();
    begin
        module_id = 16'h0042;
        run_command(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        // reg_write rises on edge 2, seen before edge 3
        expect_word("reg_write edge", 16'(write_edge), 16'd2);
        expect_word("stat_wr", {15'd0, stat_before}, 16'd1);
        expect_word("dest_reg", got_dest, crypto_ctrl_pkg::dest_r15);
        expect_word("reg_data_out", got_data, module_id);
        expect_word("write count", 16'(writes.size()), 16'd0);
    end
    endtask

    task automatic previous_id();
    begin
        run_command(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        expect_word("dest_reg", got_dest, crypto_ctrl_pkg::dest_r15);
        expect_word("reg_data_out", got_data, sm_prev_id);
        expect_word("write count", 16'(writes.size()), 16'd0);
    end
    endtask

    task automatic invalid_selection();
    begin
        run_command(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        expect_word("dest_reg", got_dest, crypto_ctrl_pkg::dest_r15);
        expect_word("reg_data_out", got_data, 16'd0);
        expect_word("write count", 16'(writes.size()), 16'd0);
        run_command(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        expect_word("dest_reg", got_dest, crypto_ctrl_pkg::dest_r15);
        expect_word("reg_data_out", got_data, 16'd0);
        expect_word("write count", 16'(writes.size()), 16'd0);
    end
    endtask

    task automatic disable_range(input sm_iface_pkg::word_t ps, input sm_iface_pkg::word_t pe,
                                 input sm_iface_pkg::word_t ss, input sm_iface_pkg::word_t se);
    begin
        pub_start = ps;
        pub_end = pe;
        sec_start = ss;
        sec_end = se;
        expected.delete();
        add_range(ps, pe);
        add_range(ss, se);
        run_command(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        expect_word("dest_reg", got_dest, crypto_ctrl_pkg::dest_pc);
        expect_word("reg_data_out", got_data, r15);
        expect_word("busy", {15'd0, busy_at_write}, 16'd1);
        compare_writes();
    end
    endtask

    task automatic disable_random();
        logic [31:0]         rnd;
        sm_iface_pkg::word_t ps;
        sm_iface_pkg::word_t pe;
        sm_iface_pkg::word_t ss;
        sm_iface_pkg::word_t se;
        int                  k;
    begin
        for (k = 0; k < 4; k++)
        begin
            rnd = $random(seed);
            ps = 16'h2000 + {7'd0, rnd[7:0], 1'b0};
            pe = ps + {11'd0, rnd[11:8], 1'b0};
            ss = 16'h6000 + {7'd0, rnd[19:12], 1'b0};
            se = ss + {11'd0, rnd[23:20], 1'b0};
            // first pass has an empty secret range
            if (k == 0)
                se = ss;
            disable_range(ps, pe, ss, se);
        end
    end
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        cmd_disable = 1'b0;
        cmd_id = 1'b0;
        cmd_id_prev = 1'b0;
        pc = 16'h1234;
        r15 = 16'h5a5a;
        sm_prev_id = 16'h0777;
        sm_data_select_valid = 1'b0;
        sm_key_select_valid = 1'b0;
        pub_start = '0;
        pub_end = '0;
        sec_start = '0;
        sec_end = '0;
        module_id = '0;
        checks = 0;
        errors = 0;
        seed = 32;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_after_reset();
        identify_valid();
        previous_id();
        invalid_selection();
        disable_range(16'h1000, 16'h1008, 16'h4010, 16'h4016);
        // start above end gives a single write
        disable_range(16'h1100, 16'h10f0, 16'h4200, 16'h4204);
        disable_random();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
src/sm_iface_pkg.sv
src/crypto_ctrl_pkg.sv
src/sm_command_sequencer.sv
src/address_walker.sv
src/result_writeback.sv
src/crypto_control.sv
testbench/tb_crypto_control.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_crypto_control -f project.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "*** TEST FAILED ***" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
